/* hdl/streamer_settings.svh */
// Build-time widths, depth, version and register map, included by the package and RTL
`ifndef STREAMER_SETTINGS_SVH
`define STREAMER_SETTINGS_SVH

// ======================================================================
// Data path sizing
// ======================================================================

// Bits in one pattern word
`define PATTERN_WIDTH 32

// Words held by each looping FIFO
`define PATTERN_DEPTH 16

// Bits in a register index on the host port
`define REG_INDEX_WIDTH 4

// Bump whenever the register map changes
`define MODULE_VERSION 32'd1

// ======================================================================
// Register map
// ======================================================================
`define REG_MODULE_REV 0
`define REG_FIFO_CTL   1
`define REG_LOAD_F0    2
`define REG_LOAD_F1    3
`define REG_START      4
`define REG_STAGE      5

`endif

/* hdl/streamer_pkg.sv */
// Shared types for the pattern streamer, imported by every RTL module
`default_nettype none

`include "streamer_settings.svh"

package streamer_pkg;

   // ===================================================================
   // Basic words and counts
   // ===================================================================

   // One pattern word as it travels through a FIFO and out the stream
   typedef logic [`PATTERN_WIDTH-1:0] pattern_t;

   // Register index on the host port
   typedef logic [`REG_INDEX_WIDTH-1:0] reg_index_t;

   // Holds 0 up to and including a full FIFO
   typedef logic [$clog2(`PATTERN_DEPTH + 1)-1:0] fifo_count_t;

   // One-hot FIFO select
   // Bit 0 is FIFO 0, bit 1 is FIFO 1, zero is none
   typedef logic [1:0] fifo_sel_t;

   // Host port response codes
   typedef enum logic [1:0] {
      OKAY   = 2'd0,
      DECERR = 2'd3
   } resp_t;

   // ===================================================================
   // Write word decoding
   // ===================================================================

   // Control word at the FIFO control register, bit 0 is f0_clear
   typedef struct packed {
      logic [`PATTERN_WIDTH-5:0] reserved;
      logic                      f1_load;
      logic                      f0_load;
      logic                      f1_clear;
      logic                      f0_clear;
   } fifo_ctl_t;

   // Same write word seen as control bits or as a pattern
   typedef union packed {
      pattern_t  pattern;
      fifo_ctl_t ctl;
   } reg_word_u;

endpackage

`default_nettype wire

/* hdl/emu_regs.sv */
// Host register block: decodes strobed writes into load, clear and start, returns read-back
`default_nettype none

`include "streamer_settings.svh"

module emu_regs (
   input  wire                      clk,
   input  wire                      resetn,
   // Write strobe port
   input  wire                      wr_strobe,
   input  wire streamer_pkg::reg_index_t  wr_index,
   input  wire streamer_pkg::reg_word_u   wr_data,
   output streamer_pkg::resp_t            wr_resp,
   // Read strobe port
   input  wire                      rd_strobe,
   input  wire streamer_pkg::reg_index_t  rd_index,
   output streamer_pkg::pattern_t         rd_data,
   output streamer_pkg::resp_t            rd_resp,
   // FIFO status
   input  wire streamer_pkg::fifo_count_t f0_count,
   input  wire streamer_pkg::fifo_count_t f1_count,
   input  wire streamer_pkg::fifo_sel_t   active,
   // FIFO control pulses
   output logic                     f0_load,
   output logic                     f1_load,
   output logic                     f0_clear,
   output logic                     f1_clear,
   output streamer_pkg::pattern_t         load_data,
   output streamer_pkg::fifo_sel_t        on_deck
);
   import streamer_pkg::*;

   // Word that a control-register load pushes into a FIFO
   pattern_t stage;

   // ===================================================================
   // Write decode
   // ===================================================================
   always_ff @(posedge clk) begin
      // Load and clear are single-cycle pulses
      f0_load  <= 1'b0;
      f1_load  <= 1'b0;
      f0_clear <= 1'b0;
      f1_clear <= 1'b0;

      if (!resetn) begin
         wr_resp <= OKAY;
         on_deck <= '0;
      end else if (wr_strobe) begin
         wr_resp <= OKAY;
         case (wr_index)
            // Version is read-only, write accepted and dropped
            `REG_MODULE_REV: ;

            // A playing FIFO ignores both load and clear
            `REG_FIFO_CTL: begin
               f0_clear <= wr_data.ctl.f0_clear & ~active[0];
               f1_clear <= wr_data.ctl.f1_clear & ~active[1];
               f0_load  <= wr_data.ctl.f0_load  & ~active[0];
               f1_load  <= wr_data.ctl.f1_load  & ~active[1];
            end

            // Immediate loads
            `REG_LOAD_F0: f0_load <= ~active[0];
            `REG_LOAD_F1: f1_load <= ~active[1];

            // Only one FIFO at a time, and never an empty one
            `REG_START: begin
               case (wr_data.pattern[1:0])
                  2'b00: on_deck <= '0;
                  2'b01: if (f0_count != '0) on_deck <= 2'b01;
                  2'b10: if (f1_count != '0) on_deck <= 2'b10;
                  default: ;
               endcase
            end

            `REG_STAGE: ;

            default: wr_resp <= DECERR;
         endcase
      end
   end

   // Staging word and the word carried with a load pulse
   always_ff @(posedge clk) begin
      if (wr_strobe) begin
         case (wr_index)
            `REG_FIFO_CTL: load_data <= stage;
            `REG_LOAD_F0:  load_data <= wr_data.pattern;
            `REG_LOAD_F1:  load_data <= wr_data.pattern;
            `REG_STAGE:    stage     <= wr_data.pattern;
            default: ;
         endcase
      end
   end

   // ===================================================================
   // Read-back
   // ===================================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         rd_data <= '0;
         rd_resp <= OKAY;
      end else if (rd_strobe) begin
         rd_resp <= OKAY;
         case (rd_index)
            `REG_MODULE_REV: rd_data <= `MODULE_VERSION;
            // Control bits are strobes, nothing to return
            `REG_FIFO_CTL:   rd_data <= '0;
            `REG_LOAD_F0:    rd_data <= pattern_t'(f0_count);
            `REG_LOAD_F1:    rd_data <= pattern_t'(f1_count);
            // Reports what is playing, not what is on deck
            `REG_START:      rd_data <= pattern_t'(active);
            `REG_STAGE:      rd_data <= stage;
            default: begin
               rd_data <= '0;
               rd_resp <= DECERR;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* hdl/loop_fifo.sv */
// Circular pattern buffer; a pop recirculates the head word to the tail so contents loop
`default_nettype none

`include "streamer_settings.svh"

module loop_fifo #(
   parameter int depth = `PATTERN_DEPTH
) (
   input  wire                            clk,
   input  wire                            resetn,
   input  wire                            clear,
   input  wire                            load,
   input  wire streamer_pkg::pattern_t    load_data,
   input  wire                            pop,
   output streamer_pkg::pattern_t         head,
   output streamer_pkg::fifo_count_t      count
);
   import streamer_pkg::*;

   localparam int ptr_w = $clog2(depth);

   pattern_t         mem [depth];
   logic [ptr_w-1:0] head_ptr;
   logic [ptr_w-1:0] tail_ptr;
   logic             pop_ok;
   logic             load_ok;

   // Pointer wrap for depths that are not a power of two
   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
      return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Pop wins over a colliding load, both share the tail slot
   assign pop_ok  = pop && (count != '0);
   assign load_ok = load && !pop_ok && (count != fifo_count_t'(depth));

   assign head = mem[head_ptr];

   // Storage
   always_ff @(posedge clk) begin
      if (pop_ok)
         mem[tail_ptr] <= mem[head_ptr];
      else if (load_ok)
         mem[tail_ptr] <= load_data;
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         head_ptr <= '0;
         tail_ptr <= '0;
         count    <= '0;
      end else if (pop_ok) begin
         // Word moves head to tail, occupancy unchanged
         head_ptr <= next_ptr(head_ptr);
         tail_ptr <= next_ptr(tail_ptr);
      end else if (load_ok) begin
         tail_ptr <= next_ptr(tail_ptr);
         count    <= count + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* hdl/stream_sequencer.sv */
// Output sequencer: plays the on-deck FIFO pass by pass over a valid/ready stream
`default_nettype none

module stream_sequencer (
   input  wire                            clk,
   input  wire                            resetn,
   input  wire streamer_pkg::fifo_sel_t   on_deck,
   input  wire streamer_pkg::fifo_count_t f0_count,
   input  wire streamer_pkg::fifo_count_t f1_count,
   input  wire streamer_pkg::pattern_t    f0_head,
   input  wire streamer_pkg::pattern_t    f1_head,
   output streamer_pkg::fifo_sel_t        active,
   output logic                           f0_pop,
   output logic                           f1_pop,
   // Output stream
   output streamer_pkg::pattern_t         tdata,
   output logic                           tvalid,
   input  wire                            tready
);
   import streamer_pkg::*;

   // Transfers left in the current pass
   fifo_count_t remaining;

   logic xfer;
   logic pass_end;
   logic start_f0;
   logic start_f1;

   assign xfer     = tvalid & tready;
   assign pass_end = xfer && (remaining == fifo_count_t'(1));

   // On-deck FIFO only counts if it holds something
   assign start_f0 = (on_deck == 2'b01) && (f0_count != '0);
   assign start_f1 = (on_deck == 2'b10) && (f1_count != '0);

   // Head of the active FIFO drives the stream
   // Held stable until the transfer since loads are blocked while active
   always_comb begin
      case (active)
         2'b01:   tdata = f0_head;
         2'b10:   tdata = f1_head;
         default: tdata = '0;
      endcase
   end

   // Pop only on a real transfer
   assign f0_pop = xfer & active[0];
   assign f1_pop = xfer & active[1];

   // ===================================================================
   // Selection and pass counting
   // ===================================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         active    <= '0;
         tvalid    <= 1'b0;
         remaining <= '0;
      end else if (!tvalid || pass_end) begin
         // Idle or at a pass boundary, pick up on_deck with no gap
         if (start_f0) begin
            active    <= 2'b01;
            remaining <= f0_count;
            tvalid    <= 1'b1;
         end else if (start_f1) begin
            active    <= 2'b10;
            remaining <= f1_count;
            tvalid    <= 1'b1;
         end else begin
            active <= '0;
            tvalid <= 1'b0;
         end
      end else if (xfer) begin
         remaining <= remaining - 1'b1;
      end
      // Back-pressure leaves everything held
   end

endmodule

`default_nettype wire

/* hdl/pattern_streamer.sv */
// Top of the pattern streamer: register block, two looping FIFOs and the output sequencer
`default_nettype none

`include "streamer_settings.svh"

module pattern_streamer (
   input  wire                            clk,
   input  wire                            resetn,
   // Host register port
   input  wire                            wr_strobe,
   input  wire streamer_pkg::reg_index_t  wr_index,
   input  wire streamer_pkg::reg_word_u   wr_data,
   output streamer_pkg::resp_t            wr_resp,
   input  wire                            rd_strobe,
   input  wire streamer_pkg::reg_index_t  rd_index,
   output streamer_pkg::pattern_t         rd_data,
   output streamer_pkg::resp_t            rd_resp,
   // Output stream
   output streamer_pkg::pattern_t         tdata,
   output logic                           tvalid,
   input  wire                            tready,
   // High while any FIFO is playing
   output logic                           enable
);
   import streamer_pkg::*;

   // ===================================================================
   // Internal connections
   // ===================================================================
   logic        f0_load;
   logic        f1_load;
   logic        f0_clear;
   logic        f1_clear;
   logic        f0_pop;
   logic        f1_pop;
   pattern_t    load_data;
   pattern_t    f0_head;
   pattern_t    f1_head;
   fifo_count_t f0_count;
   fifo_count_t f1_count;
   fifo_sel_t   on_deck;
   fifo_sel_t   active;

   assign enable = |active;

   emu_regs regs0 (
      .clk       (clk),
      .resetn    (resetn),
      .wr_strobe (wr_strobe),
      .wr_index  (wr_index),
      .wr_data   (wr_data),
      .wr_resp   (wr_resp),
      .rd_strobe (rd_strobe),
      .rd_index  (rd_index),
      .rd_data   (rd_data),
      .rd_resp   (rd_resp),
      .f0_count  (f0_count),
      .f1_count  (f1_count),
      .active    (active),
      .f0_load   (f0_load),
      .f1_load   (f1_load),
      .f0_clear  (f0_clear),
      .f1_clear  (f1_clear),
      .load_data (load_data),
      .on_deck   (on_deck)
   );

   // Both FIFOs share the load word, the pulses pick the target
   loop_fifo #(.depth(`PATTERN_DEPTH)) fifo_0 (
      .clk       (clk),
      .resetn    (resetn),
      .clear     (f0_clear),
      .load      (f0_load),
      .load_data (load_data),
      .pop       (f0_pop),
      .head      (f0_head),
      .count     (f0_count)
   );

   loop_fifo #(.depth(`PATTERN_DEPTH)) fifo_1 (
      .clk       (clk),
      .resetn    (resetn),
      .clear     (f1_clear),
      .load      (f1_load),
      .load_data (load_data),
      .pop       (f1_pop),
      .head      (f1_head),
      .count     (f1_count)
   );

   stream_sequencer seq0 (
      .clk      (clk),
      .resetn   (resetn),
      .on_deck  (on_deck),
      .f0_count (f0_count),
      .f1_count (f1_count),
      .f0_head  (f0_head),
      .f1_head  (f1_head),
      .active   (active),
      .f0_pop   (f0_pop),
      .f1_pop   (f1_pop),
      .tdata    (tdata),
      .tvalid   (tvalid),
      .tready   (tready)
   );

endmodule

`default_nettype wire

/* tests/tb_pattern_streamer.sv */
// Table-driven testbench for pattern_streamer; run the file list through Verilator from run_sim.sh
`default_nettype none

`include "streamer_settings.svh"

module tb_pattern_streamer;

   // ===================================================================
   // Step table
   // ===================================================================
   localparam logic [1:0] K_WRITE = 2'd0;
   localparam logic [1:0] K_READ  = 2'd1;
   localparam logic [1:0] K_PLAY  = 2'd2;
   localparam logic [1:0] K_IDLE  = 2'd3;

   // Response codes of the host port
   localparam logic [1:0] R_OKAY   = 2'd0;
   localparam logic [1:0] R_DECERR = 2'd3;

   // Data is write data, expected read data, or word count for a play step
   typedef struct packed {
      logic [1:0]  kind;
      logic [3:0]  index;
      logic [31:0] data;
      logic [1:0]  resp;
   } step_t;

   step_t steps[$];

   logic        clk;
   logic        resetn;
   logic        wr_strobe;
   logic [3:0]  wr_index;
   logic [31:0] wr_data;
   logic [1:0]  wr_resp;
   logic        rd_strobe;
   logic [3:0]  rd_index;
   logic [31:0] rd_data;
   logic [1:0]  rd_resp;
   logic [31:0] tdata;
   logic        tvalid;
   logic        tready;
   logic        enable;

   // Reference model of both FIFOs and the sequencer
   logic [31:0] model_q0[$];
   logic [31:0] model_q1[$];
   logic [31:0] m_stage;
   logic [1:0]  m_on_deck;
   logic [1:0]  m_active;
   int          m_remaining;
   int          xfer_count;
   int          cycle_count;
   int          cycle_limit;
   logic [31:0] lfsr;

   pattern_streamer dut0 (
      .clk       (clk),
      .resetn    (resetn),
      .wr_strobe (wr_strobe),
      .wr_index  (wr_index),
      .wr_data   (wr_data),
      .wr_resp   (wr_resp),
      .rd_strobe (rd_strobe),
      .rd_index  (rd_index),
      .rd_data   (rd_data),
      .rd_resp   (rd_resp),
      .tdata     (tdata),
      .tvalid    (tvalid),
      .tready    (tready),
      .enable    (enable)
   );

   // ===================================================================
   // Failure handling and checks
   // ===================================================================
   task fail_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped on error");
   endtask

   task compare_value(input string name, input logic [31:0] got, input logic [31:0] expected);
      if (got !== expected)
         fail_run($sformatf("Fail at time %0t: %s is 0x%08h, expected 0x%08h",
                            $time, name, got, expected));
   endtask

   // Galois form with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task add_step(input logic [1:0] kind, input logic [3:0] index, input logic [31:0] data,
                 input logic [1:0] resp);
      step_t s;
      s.kind  = kind;
      s.index = index;
      s.data  = data;
      s.resp  = resp;
      steps.push_back(s);
   endtask

   // Rough cycle cost of one step
   // Random tready lets about half the cycles through
   function automatic int step_cycles(input step_t s);
      case (s.kind)
         K_WRITE: return 3;
         K_READ:  return 3;
         K_PLAY:  return 2 * int'(s.data) + 8;
         default: return 40;
      endcase
   endfunction

   // ===================================================================
   // Clock, back-pressure and timeout
   // ===================================================================
   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // One LFSR bit per cycle for tready
   initial begin
      tready = 1'b0;
      lfsr   = 32'h2fec_fbba;
      forever begin
         @(posedge clk);
         lfsr = lfsr_next(lfsr);
         tready <= lfsr[0];
      end
   end

   initial cycle_count = 0;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit)
         fail_run($sformatf("Timeout: run went past %0d cycles", cycle_limit));
   end

   // ===================================================================
   // Stream scoreboard
   // ===================================================================
   // Next selection at a pass boundary
   // Nothing plays if the on-deck FIFO is empty
   task pick_next();
      if (m_on_deck == 2'b01 && model_q0.size() != 0) begin
         m_active    = 2'b01;
         m_remaining = model_q0.size();
      end else if (m_on_deck == 2'b10 && model_q1.size() != 0) begin
         m_active    = 2'b10;
         m_remaining = model_q1.size();
      end else begin
         m_active = 2'b00;
      end
   endtask

   task check_transfer();
      logic [31:0] expected_word;
      if (m_active == 2'b00)
         pick_next();
      if (m_active == 2'b00)
         fail_run("Stream transfer seen while no FIFO should be playing");
      compare_value("enable", 32'(enable), 32'd1);
      // Word leaves the head and comes back at the tail
      if (m_active == 2'b01) begin
         expected_word = model_q0.pop_front();
         model_q0.push_back(expected_word);
      end else begin
         expected_word = model_q1.pop_front();
         model_q1.push_back(expected_word);
      end
      compare_value("tdata", tdata, expected_word);
      m_remaining = m_remaining - 1;
      if (m_remaining == 0)
         pick_next();
      xfer_count = xfer_count + 1;
   endtask

   task load_model(input int fifo, input logic [31:0] word);
      if (fifo == 0 && model_q0.size() < `PATTERN_DEPTH)
         model_q0.push_back(word);
      if (fifo == 1 && model_q1.size() < `PATTERN_DEPTH)
         model_q1.push_back(word);
   endtask

   // Writes act on the FIFO selection that held before this edge
   task apply_write(input logic [1:0] prev_active);
      case (wr_index)
         `REG_FIFO_CTL: begin
            // Clear wins over a load in the same word
            if (prev_active != 2'b01) begin
               if (wr_data[0])
                  model_q0.delete();
               else if (wr_data[2])
                  load_model(0, m_stage);
            end
            if (prev_active != 2'b10) begin
               if (wr_data[1])
                  model_q1.delete();
               else if (wr_data[3])
                  load_model(1, m_stage);
            end
         end
         `REG_LOAD_F0: if (prev_active != 2'b01) load_model(0, wr_data);
         `REG_LOAD_F1: if (prev_active != 2'b10) load_model(1, wr_data);
         `REG_START: begin
            case (wr_data[1:0])
               2'b00: m_on_deck = 2'b00;
               2'b01: if (model_q0.size() != 0) m_on_deck = 2'b01;
               2'b10: if (model_q1.size() != 0) m_on_deck = 2'b10;
               default: ;
            endcase
         end
         `REG_STAGE: m_stage = wr_data;
         default: ;
      endcase
   endtask

   // Inputs and outputs are settled at the falling edge
   always @(negedge clk) begin
      logic [1:0] prev_active;
      prev_active = m_active;
      if (resetn && tvalid && tready)
         check_transfer();
      if (resetn && wr_strobe)
         apply_write(prev_active);
   end

   // ===================================================================
   // Host port tasks
   // ===================================================================
   task write_reg(input logic [3:0] index, input logic [31:0] data, input logic [1:0] resp);
      @(posedge clk);
      wr_strobe <= 1'b1;
      wr_index  <= index;
      wr_data   <= data;
      @(posedge clk);
      wr_strobe <= 1'b0;
      @(negedge clk);
      compare_value("wr_resp", 32'(wr_resp), 32'(resp));
   endtask

   task read_reg(input logic [3:0] index, input logic [31:0] expected, input logic [1:0] resp);
      @(posedge clk);
      rd_strobe <= 1'b1;
      rd_index  <= index;
      @(posedge clk);
      rd_strobe <= 1'b0;
      @(negedge clk);
      compare_value("rd_resp", 32'(rd_resp), 32'(resp));
      compare_value("rd_data", rd_data, expected);
   endtask

   task play_words(input int count);
      int target;
      target = xfer_count + count;
      while (xfer_count < target)
         @(posedge clk);
   endtask

   // Stream must stop and stay stopped
   task wait_idle();
      while (tvalid)
         @(negedge clk);
      repeat (4) @(negedge clk);
      compare_value("tvalid", 32'(tvalid), 32'd0);
      compare_value("enable", 32'(enable), 32'd0);
   endtask

   // ===================================================================
   // Main sequence
   // ===================================================================
   initial begin
      int total;
      resetn      = 1'b0;
      wr_strobe   = 1'b0;
      wr_index    = '0;
      wr_data     = '0;
      rd_strobe   = 1'b0;
      rd_index    = '0;
      m_stage     = '0;
      m_on_deck   = 2'b00;
      m_active    = 2'b00;
      m_remaining = 0;
      xfer_count  = 0;

      // Version, unmapped index and idle state after reset
      add_step(K_IDLE,  4'h0, 32'd0, R_OKAY);
      add_step(K_READ,  `REG_MODULE_REV, `MODULE_VERSION, R_OKAY);
      add_step(K_READ,  4'hF, 32'd0, R_DECERR);
      add_step(K_WRITE, 4'hF, 32'h1234_5678, R_DECERR);
      add_step(K_READ,  `REG_START, 32'd0, R_OKAY);
      // Immediate loads into FIFO 0 and a staged load into FIFO 1
      add_step(K_WRITE, `REG_LOAD_F0, 32'hA5A5_0001, R_OKAY);
      add_step(K_WRITE, `REG_LOAD_F0, 32'h5A5A_0002, R_OKAY);
      add_step(K_WRITE, `REG_LOAD_F0, 32'hC3C3_0003, R_OKAY);
      add_step(K_READ,  `REG_LOAD_F0, 32'd3, R_OKAY);
      add_step(K_WRITE, `REG_STAGE, 32'h7E57_0F11, R_OKAY);
      add_step(K_WRITE, `REG_FIFO_CTL, 32'h0000_0008, R_OKAY);
      add_step(K_READ,  `REG_LOAD_F1, 32'd1, R_OKAY);
      add_step(K_READ,  `REG_STAGE, 32'h7E57_0F11, R_OKAY);
      add_step(K_READ,  `REG_FIFO_CTL, 32'd0, R_OKAY);
      // Play FIFO 0 for three passes and one word
      add_step(K_WRITE, `REG_START, 32'd1, R_OKAY);
      add_step(K_READ,  `REG_START, 32'd1, R_OKAY);
      add_step(K_PLAY,  4'h0, 32'd10, R_OKAY);
      // Switch mid-pass so the change lands on the next boundary
      add_step(K_WRITE, `REG_START, 32'd2, R_OKAY);
      add_step(K_PLAY,  4'h0, 32'd6, R_OKAY);
      add_step(K_READ,  `REG_START, 32'd2, R_OKAY);
      // Clear and load of the playing FIFO are dropped
      add_step(K_WRITE, `REG_FIFO_CTL, 32'h0000_0002, R_OKAY);
      add_step(K_WRITE, `REG_LOAD_F1, 32'h0000_BEEF, R_OKAY);
      add_step(K_READ,  `REG_LOAD_F1, 32'd1, R_OKAY);
      add_step(K_PLAY,  4'h0, 32'd3, R_OKAY);
      add_step(K_WRITE, `REG_START, 32'd0, R_OKAY);
      add_step(K_IDLE,  4'h0, 32'd0, R_OKAY);
      add_step(K_READ,  `REG_START, 32'd0, R_OKAY);
      // Empty FIFO refuses to start
      add_step(K_WRITE, `REG_FIFO_CTL, 32'h0000_0001, R_OKAY);
      add_step(K_READ,  `REG_LOAD_F0, 32'd0, R_OKAY);
      add_step(K_WRITE, `REG_START, 32'd1, R_OKAY);
      add_step(K_READ,  `REG_START, 32'd0, R_OKAY);
      add_step(K_IDLE,  4'h0, 32'd0, R_OKAY);
      // A refused start stays refused once the FIFO fills again
      add_step(K_WRITE, `REG_LOAD_F0, 32'h0DD5_0004, R_OKAY);
      add_step(K_READ,  `REG_LOAD_F0, 32'd1, R_OKAY);
      add_step(K_IDLE,  4'h0, 32'd0, R_OKAY);
      add_step(K_READ,  `REG_START, 32'd0, R_OKAY);

      total = 5;
      foreach (steps[i])
         total = total + step_cycles(steps[i]);
      cycle_limit = 4 * total;

      repeat (5) @(posedge clk);
      resetn <= 1'b1;

      for (int i = 0; i < steps.size(); i++) begin
         case (steps[i].kind)
            K_WRITE: write_reg(steps[i].index, steps[i].data, steps[i].resp);
            K_READ:  read_reg(steps[i].index, steps[i].data, steps[i].resp);
            K_PLAY:  play_words(int'(steps[i].data));
            default: wait_idle();
         endcase
      end

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hdl
hdl/streamer_pkg.sv
hdl/emu_regs.sv
hdl/loop_fifo.sv
hdl/stream_sequencer.sv
hdl/pattern_streamer.sv
tests/tb_pattern_streamer.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the pattern streamer testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
   -f flist.f \
   --top-module tb_pattern_streamer \
   -Mdir obj_dir \
   -o sim_pattern_streamer
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit $build_status
fi

./obj_dir/sim_pattern_streamer
sim_status=$?
if [ $sim_status -ne 0 ]; then
   echo "Simulation ended with status $sim_status"
   exit $sim_status
fi

exit 0
